// File: hw/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // ############################
    // Sizes
    // ############################

    localparam int xlen        = 32;
    localparam int reg_id_w    = 5;
    localparam int reg_count   = 32;
    localparam int shamt_w     = 5;
    localparam int num_src     = 2;   // Source operands per instruction.
    localparam int dmem_words  = 64;
    localparam int dmem_addr_w = $clog2(dmem_words);

    // ############################
    // Encodings
    // ############################

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        add  = 3'b000,   // Also sub when funct7_5 is set.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,   // Logical or arithmetic by funct7_5.
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // Operand select in EX, one per source.
    typedef enum logic [1:0] {
        no_forward      = 2'b00,
        mem_alu_out     = 2'b01,
        regfile_mux_out = 2'b10
    } ex_fwd_sel_t;

    // Store data select in MEM.
    typedef enum logic {
        wb_no_forward      = 1'b0,
        wb_regfile_mux_out = 1'b1
    } wb_mem_fwd_sel_t;

    // ############################
    // Pipeline control word
    // ############################

    typedef struct packed {
        logic                valid;
        rv32i_opcode         opcode;
        logic [2:0]          funct3;
        logic                funct7_5;
        logic [reg_id_w-1:0] rs1_id;
        logic [reg_id_w-1:0] rs2_id;
        logic [reg_id_w-1:0] rd_id;
        logic                load_regfile;
        logic [xlen-1:0]     imm;
    } rv32i_control_word;

endpackage : rv32i_pkg

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [rv32i_pkg::reg_id_w-1:0] rs1_id,
    input  logic [rv32i_pkg::reg_id_w-1:0] rs2_id,
    input  logic                           we,
    input  logic [rv32i_pkg::reg_id_w-1:0] wr_id,
    input  logic [rv32i_pkg::xlen-1:0]     wr_data,
    output logic [rv32i_pkg::xlen-1:0]     rs1_data,
    output logic [rv32i_pkg::xlen-1:0]     rs2_data
);

    logic [rv32i_pkg::xlen-1:0] regs [1:rv32i_pkg::reg_count-1];   // x0 has no storage.

    // x0 reads as zero, a same-cycle write is passed straight through.
    function automatic logic [rv32i_pkg::xlen-1:0] read_port(
        input logic [rv32i_pkg::reg_id_w-1:0] id
    );
        if (id == '0)
            return '0;
        else if (we && (wr_id == id))
            return wr_data;
        else
            return regs[id];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < rv32i_pkg::reg_count; i++)
                regs[i] <= '0;
        end
        else if (we && (wr_id != '0))
        begin
            regs[wr_id] <= wr_data;
        end
    end

    assign rs1_data = read_port(rs1_id);
    assign rs2_data = read_port(rs2_id);

endmodule : reg_file

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    input  logic [rv32i_pkg::xlen-1:0]          rs1_data,
    input  logic [rv32i_pkg::xlen-1:0]          rs2_data,
    output logic [rv32i_pkg::reg_id_w-1:0]      rs1_id,
    output logic [rv32i_pkg::reg_id_w-1:0]      rs2_id,
    output rv32i_pkg::rv32i_control_word        id_ex_ctrl,
    output logic [rv32i_pkg::xlen-1:0]          id_ex_rs1,
    output logic [rv32i_pkg::xlen-1:0]          id_ex_rs2
);

    rv32i_pkg::rv32i_control_word ctrl;
    logic [rv32i_pkg::xlen-1:0]   imm_i;
    logic [rv32i_pkg::xlen-1:0]   imm_s;
    logic [rv32i_pkg::xlen-1:0]   imm_u;

    assign imm_i = {{(rv32i_pkg::xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(rv32i_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // ############################
    // Field decode
    // ############################

    always_comb
    begin
        ctrl          = '0;
        ctrl.valid    = instr_valid;
        ctrl.opcode   = rv32i_pkg::rv32i_opcode'(instr[6:0]);
        ctrl.funct3   = instr[14:12];
        ctrl.funct7_5 = instr[30];
        ctrl.rs1_id   = instr[19:15];
        ctrl.rs2_id   = instr[24:20];
        ctrl.rd_id    = instr[11:7];

        case (ctrl.opcode)
            rv32i_pkg::op_reg:
            begin
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_imm, rv32i_pkg::op_load:
            begin
                ctrl.imm          = imm_i;
                ctrl.rs2_id       = '0;   // Field holds immediate bits.
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_lui:
            begin
                ctrl.imm          = imm_u;
                ctrl.rs1_id       = '0;   // Result is 0 + imm.
                ctrl.rs2_id       = '0;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_store:
            begin
                ctrl.imm = imm_s;
            end
            default: ;   // Unknown opcode writes nothing.
        endcase
    end

    assign rs1_id = ctrl.rs1_id;
    assign rs2_id = ctrl.rs2_id;

    // ID/EX register.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            id_ex_ctrl <= '0;
        else
            id_ex_ctrl <= ctrl;
        id_ex_rs1 <= rs1_data;
        id_ex_rs2 <= rs2_data;
    end

endmodule : decode_stage

`default_nettype wire

// File: hw/forward_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_control_unit (
    input  rv32i_pkg::rv32i_control_word                       id_ex_ctrl,
    input  rv32i_pkg::rv32i_control_word                       ex_mem_ctrl,
    input  rv32i_pkg::rv32i_control_word                       mem_wb_ctrl,
    output rv32i_pkg::ex_fwd_sel_t [rv32i_pkg::num_src-1:0]    ex_fwd_sel,
    output rv32i_pkg::wb_mem_fwd_sel_t                         wb_mem_fwd_sel
);

    logic [rv32i_pkg::num_src-1:0][rv32i_pkg::reg_id_w-1:0] src_id;
    logic mem_produces;   // MEM stage holds an ALU result for a real register.
    logic wb_produces;

    assign src_id[0] = id_ex_ctrl.rs1_id;
    assign src_id[1] = id_ex_ctrl.rs2_id;

    // Load data is not ready until WB.
    assign mem_produces = ex_mem_ctrl.valid && ex_mem_ctrl.load_regfile &&
                          (ex_mem_ctrl.rd_id != '0) &&
                          (ex_mem_ctrl.opcode != rv32i_pkg::op_load);

    assign wb_produces = mem_wb_ctrl.valid && mem_wb_ctrl.load_regfile &&
                         (mem_wb_ctrl.rd_id != '0);

    // ############################
    // MEM-EX and WB-EX
    // ############################

    always_comb
    begin
        for (int i = 0; i < rv32i_pkg::num_src; i++)
        begin
            if (mem_produces && (ex_mem_ctrl.rd_id == src_id[i]))
                ex_fwd_sel[i] = rv32i_pkg::mem_alu_out;     // Youngest producer wins.
            else if (wb_produces && (mem_wb_ctrl.rd_id == src_id[i]))
                ex_fwd_sel[i] = rv32i_pkg::regfile_mux_out;
            else
                ex_fwd_sel[i] = rv32i_pkg::no_forward;
        end
    end

    // ############################
    // WB-MEM
    // ############################

    always_comb
    begin
        if (wb_produces && (mem_wb_ctrl.opcode == rv32i_pkg::op_load) &&
            ex_mem_ctrl.valid && (ex_mem_ctrl.opcode == rv32i_pkg::op_store) &&
            (mem_wb_ctrl.rd_id == ex_mem_ctrl.rs2_id))
            wb_mem_fwd_sel = rv32i_pkg::wb_regfile_mux_out;
        else
            wb_mem_fwd_sel = rv32i_pkg::wb_no_forward;
    end

endmodule : forward_control_unit

`default_nettype wire

// File: hw/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  rv32i_pkg::ex_fwd_sel_t         sel,
    input  logic [rv32i_pkg::xlen-1:0]     reg_value,
    input  logic [rv32i_pkg::xlen-1:0]     mem_alu_out,
    input  logic [rv32i_pkg::xlen-1:0]     regfile_mux_out,
    output logic [rv32i_pkg::xlen-1:0]     operand
);

    always_comb
    begin
        case (sel)
            rv32i_pkg::mem_alu_out:     operand = mem_alu_out;
            rv32i_pkg::regfile_mux_out: operand = regfile_mux_out;   // WB value.
            default:                    operand = reg_value;
        endcase
    end

endmodule : operand_bypass

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  rv32i_pkg::rv32i_control_word                       id_ex_ctrl,
    input  logic [rv32i_pkg::num_src-1:0][rv32i_pkg::xlen-1:0] operand,
    output rv32i_pkg::rv32i_control_word                       ex_mem_ctrl,
    output logic [rv32i_pkg::xlen-1:0]                         ex_mem_alu_out,
    output logic [rv32i_pkg::xlen-1:0]                         ex_mem_store_data
);

    logic [rv32i_pkg::xlen-1:0]    op_a;
    logic [rv32i_pkg::xlen-1:0]    op_b;
    logic [rv32i_pkg::xlen-1:0]    alu_result;
    logic [rv32i_pkg::shamt_w-1:0] shamt;
    rv32i_pkg::arith_funct3_t      alu_fn;
    logic                          is_arith;
    logic                          alt_fn;   // Sub or arithmetic shift.

    assign is_arith = (id_ex_ctrl.opcode == rv32i_pkg::op_reg) ||
                      (id_ex_ctrl.opcode == rv32i_pkg::op_imm);

    assign op_a  = operand[0];
    assign op_b  = (id_ex_ctrl.opcode == rv32i_pkg::op_reg) ? operand[1] : id_ex_ctrl.imm;
    assign shamt = op_b[rv32i_pkg::shamt_w-1:0];

    // LUI and address generation both add.
    assign alu_fn = is_arith ? rv32i_pkg::arith_funct3_t'(id_ex_ctrl.funct3) : rv32i_pkg::add;

    // Bit 30 is immediate data for most I-type, except the shift.
    assign alt_fn = id_ex_ctrl.funct7_5 &&
                    ((id_ex_ctrl.opcode == rv32i_pkg::op_reg) ||
                     ((id_ex_ctrl.opcode == rv32i_pkg::op_imm) && (alu_fn == rv32i_pkg::sr)));

    // ############################
    // ALU
    // ############################

    always_comb
    begin
        case (alu_fn)
            rv32i_pkg::add:  alu_result = alt_fn ? op_a - op_b : op_a + op_b;
            rv32i_pkg::sll:  alu_result = op_a << shamt;
            rv32i_pkg::slt:  alu_result = {{(rv32i_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv32i_pkg::sltu: alu_result = {{(rv32i_pkg::xlen-1){1'b0}}, op_a < op_b};
            rv32i_pkg::axor: alu_result = op_a ^ op_b;
            rv32i_pkg::sr:   alu_result = alt_fn ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
            rv32i_pkg::aor:  alu_result = op_a | op_b;
            default:         alu_result = op_a & op_b;
        endcase
    end

    // EX/MEM register.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ex_mem_ctrl <= '0;
        else
            ex_mem_ctrl <= id_ex_ctrl;
        ex_mem_alu_out    <= alu_result;
        ex_mem_store_data <= operand[1];   // Forwarded rs2.
    end

endmodule : execute_stage

`default_nettype wire

// File: hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rv32i_pkg::rv32i_control_word      ex_mem_ctrl,
    input  logic [rv32i_pkg::xlen-1:0]        ex_mem_alu_out,
    input  logic [rv32i_pkg::xlen-1:0]        ex_mem_store_data,
    input  rv32i_pkg::wb_mem_fwd_sel_t        wb_mem_fwd_sel,
    input  logic [rv32i_pkg::xlen-1:0]        wb_value_in,
    output rv32i_pkg::rv32i_control_word      mem_wb_ctrl,
    output logic [rv32i_pkg::xlen-1:0]        mem_wb_value
);

    logic [rv32i_pkg::xlen-1:0]        dmem [rv32i_pkg::dmem_words];
    logic [rv32i_pkg::dmem_addr_w-1:0] word_addr;
    logic [rv32i_pkg::xlen-1:0]        store_value;
    logic [rv32i_pkg::xlen-1:0]        load_value;
    logic                              do_store;

    assign word_addr = ex_mem_alu_out[rv32i_pkg::dmem_addr_w+1:2];   // Word aligned.

    // A load just ahead of the store supplies its data.
    assign store_value = (wb_mem_fwd_sel == rv32i_pkg::wb_regfile_mux_out) ?
                         wb_value_in : ex_mem_store_data;

    assign load_value = dmem[word_addr];
    assign do_store   = ex_mem_ctrl.valid && (ex_mem_ctrl.opcode == rv32i_pkg::op_store);

    // ############################
    // Data memory
    // ############################

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < rv32i_pkg::dmem_words; i++)
                dmem[i] <= '0;
        end
        else if (do_store)
        begin
            dmem[word_addr] <= store_value;
        end
    end

    // MEM/WB register.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mem_wb_ctrl <= '0;
        else
            mem_wb_ctrl <= ex_mem_ctrl;
        mem_wb_value <= (ex_mem_ctrl.opcode == rv32i_pkg::op_load) ? load_value : ex_mem_alu_out;
    end

endmodule : memory_stage

`default_nettype wire

// File: hw/int_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    output logic                              wb_valid,
    output logic [rv32i_pkg::reg_id_w-1:0]    wb_rd,
    output logic [rv32i_pkg::xlen-1:0]        wb_data
);

    logic [rv32i_pkg::reg_id_w-1:0]                         rs1_id;
    logic [rv32i_pkg::reg_id_w-1:0]                         rs2_id;
    logic [rv32i_pkg::xlen-1:0]                             rs1_data;
    logic [rv32i_pkg::xlen-1:0]                             rs2_data;
    rv32i_pkg::rv32i_control_word                           id_ex_ctrl;
    rv32i_pkg::rv32i_control_word                           ex_mem_ctrl;
    rv32i_pkg::rv32i_control_word                           mem_wb_ctrl;
    logic [rv32i_pkg::num_src-1:0][rv32i_pkg::xlen-1:0]     reg_value;
    logic [rv32i_pkg::num_src-1:0][rv32i_pkg::xlen-1:0]     operand;
    logic [rv32i_pkg::xlen-1:0]                             ex_mem_alu_out;
    logic [rv32i_pkg::xlen-1:0]                             ex_mem_store_data;
    logic [rv32i_pkg::xlen-1:0]                             mem_wb_value;
    rv32i_pkg::ex_fwd_sel_t [rv32i_pkg::num_src-1:0]        ex_fwd_sel;
    rv32i_pkg::wb_mem_fwd_sel_t                             wb_mem_fwd_sel;

    // Register write happens from the MEM/WB register.
    assign wb_valid = mem_wb_ctrl.valid && mem_wb_ctrl.load_regfile;
    assign wb_rd    = mem_wb_ctrl.rd_id;
    assign wb_data  = mem_wb_value;

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_id(rs1_id), .rs2_id(rs2_id),
        .we(wb_valid), .wr_id(wb_rd), .wr_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    decode_stage i_decode (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_id(rs1_id), .rs2_id(rs2_id),
        .id_ex_ctrl(id_ex_ctrl), .id_ex_rs1(reg_value[0]), .id_ex_rs2(reg_value[1])
    );

    forward_control_unit i_fwd_ctrl (
        .id_ex_ctrl(id_ex_ctrl), .ex_mem_ctrl(ex_mem_ctrl), .mem_wb_ctrl(mem_wb_ctrl),
        .ex_fwd_sel(ex_fwd_sel), .wb_mem_fwd_sel(wb_mem_fwd_sel)
    );

    // ############################
    // Operand bypass, one per source
    // ############################

    for (genvar g = 0; g < rv32i_pkg::num_src; g++)
    begin : g_bypass
        operand_bypass i_bypass (
            .sel(ex_fwd_sel[g]), .reg_value(reg_value[g]),
            .mem_alu_out(ex_mem_alu_out), .regfile_mux_out(mem_wb_value),
            .operand(operand[g])
        );
    end

    execute_stage i_execute (
        .clk(clk), .rst_n(rst_n),
        .id_ex_ctrl(id_ex_ctrl), .operand(operand),
        .ex_mem_ctrl(ex_mem_ctrl), .ex_mem_alu_out(ex_mem_alu_out),
        .ex_mem_store_data(ex_mem_store_data)
    );

    memory_stage i_memory (
        .clk(clk), .rst_n(rst_n),
        .ex_mem_ctrl(ex_mem_ctrl), .ex_mem_alu_out(ex_mem_alu_out),
        .ex_mem_store_data(ex_mem_store_data), .wb_mem_fwd_sel(wb_mem_fwd_sel),
        .wb_value_in(mem_wb_value),
        .mem_wb_ctrl(mem_wb_ctrl), .mem_wb_value(mem_wb_value)
    );

endmodule : int_pipe_top

`default_nettype wire

// File: test/tb_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipe;

    localparam int n_alu  = 40;
    localparam int n_rand = 300;
    // Issue slots per test including bubbles, drain and margin.
    localparam int n_slots    = 10 + 40 + 40 + n_alu * 4 + 80 + 40 + 45 + n_rand * 3 + 60;
    localparam int max_cycles = n_slots * 3 + 50;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] model_regs [32];
    logic [31:0] model_mem [64];
    int          exp_due[$];      // Edge at which the writeback is due.
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic [15:0] lfsr = 16'd34;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          errors_at_start = 0;

    int_pipe_top i_dut (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        repeat (max_cycles) @(posedge clk);
        $display("Timeout after %0d cycles with %0d writebacks pending", max_cycles, exp_due.size());
        $display("** FAIL **");
        $finish;
    end

    // ##############################
    // Helpers
    // ##############################

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1.
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I arithmetic by funct3; alt means sub or arithmetic right shift.
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s expected %h got %h at cycle %0d", name, expected, actual, cycle);
    endtask

    task automatic event_error(input string what);
        errors++;
        $display("%s at cycle %0d", what, cycle);
    endtask

    task automatic drop_head();
        void'(exp_due.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic issue(input logic [31:0] word, input logic writes,
                         input logic [4:0] rd, input logic [31:0] value);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        if (writes)
        begin
            exp_due.push_back(cycle + 4);   // Sampled at the next edge and due 3 cycles later.
            exp_rd.push_back(rd);
            exp_data.push_back(value);
            if (rd != 5'd0)
                model_regs[rd] = value;
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic alu_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        issue({1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011}, 1'b1, rd,
              ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic alu_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        issue({imm, rs1, f3, rd, 7'b0010011}, 1'b1, rd,
              ref_alu(f3, f3 == 3'd5 && imm[10], model_regs[rs1], sext(imm)));
    endtask

    task automatic nop();
        alu_ri(3'd0, 5'd0, 5'd0, 12'd0);
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
        issue({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'd0});
    endtask

    task automatic lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext(imm);
        issue({imm, rs1, 3'b010, rd, 7'b0000011}, 1'b1, rd, model_mem[addr[7:2]]);
    endtask

    task automatic sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext(imm);
        model_mem[addr[7:2]] = model_regs[rs2];
        issue({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic random_alu(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic use_imm);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand_bits(1)) : 1'b0;
        imm = 12'(rand_bits(12));
        if (f3 == 3'd1 || f3 == 3'd5)
            imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};   // Shift encoding.
        if (use_imm)
            alu_ri(f3, rd, rs1, imm);
        else
            alu_rr(f3, alt, rd, rs1, rs2);
    endtask

    task automatic finish_test(input string name);
        idle(1);
        while (exp_due.size() != 0)
            idle(1);
        idle(2);
        $display("test %s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ##############################
    // Writeback checks
    // ##############################

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (!rst_n)
        begin
            if (cycle > 1)
            begin
                checks++;
                a_reset_quiet: assert (wb_valid === 1'b0)
                    else value_error("wb_valid", 32'd0, 32'(wb_valid));
            end
        end
        else if (wb_valid !== 1'b0)
        begin
            checks++;
            a_wb_expected: assert (wb_valid === 1'b1 && exp_due.size() != 0)
                else event_error("Writeback seen with no instruction pending");
            if (exp_due.size() != 0)
            begin
                a_latency: assert (exp_due[0] == cycle)
                    else event_error($sformatf("Writeback due at cycle %0d arrived", exp_due[0]));
                a_rd: assert (wb_rd === exp_rd[0])
                    else value_error("wb_rd", 32'(exp_rd[0]), 32'(wb_rd));
                a_data: assert (wb_data === exp_data[0])
                    else value_error("wb_data", exp_data[0], wb_data);
                drop_head();
            end
        end
        else
        begin
            a_wb_on_time: assert (exp_due.size() == 0 || exp_due[0] > cycle)
                else event_error("Writeback missing for an issued instruction");
            if (exp_due.size() != 0 && exp_due[0] <= cycle)
                drop_head();
        end
    end

    // ##############################
    // Stimulus
    // ##############################

    initial
    begin
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  load_rd;
        logic [11:0] a;
        logic [11:0] b;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            model_mem[i] = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 1; i < 32; i++)
            alu_ri(3'd0, 5'(i), 5'(i), 12'd0);   // Every register reads back zero.
        finish_test("reset");

        for (int i = 1; i < 32; i++)
            lui(5'(i), 20'(rand_bits(20)));
        repeat (n_alu)
        begin
            kind = 3'(rand_bits(2));
            if (kind == 3'd2)
                lui(5'(rand_bits(5)), 20'(rand_bits(20)));
            else
                random_alu(5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)), kind == 3'd1);
            idle(3);
        end
        finish_test("alu");

        for (int d = 1; d <= 3; d++)
        begin
            repeat (4)
            begin
                alu_ri(3'd0, 5'd5, 5'd0, 12'(rand_bits(12)));
                alu_ri(3'd0, 5'd5, 5'd5, 12'(rand_bits(12)));   // Two x5 producers in flight.
                repeat (d - 1) nop();
                random_alu(5'd6, 5'd5, 5'd5, 1'b0);
                alu_ri(3'd0, 5'd0, 5'd6, 12'h7ff);
                alu_rr(3'd0, 1'b0, 5'd7, 5'd0, 5'd6);   // x0 must still read zero.
            end
        end
        finish_test("forwarding");

        repeat (6)
        begin
            a = 12'(rand_bits(6) * 4);
            random_alu(5'd9, 5'd7, 5'd6, 1'b0);
            sw(5'd9, 5'd0, a);
            lw(5'd10, 5'd0, a);
            nop();
            alu_rr(3'd0, 1'b0, 5'd11, 5'd10, 5'd9);
        end
        finish_test("load");

        repeat (6)
        begin
            a = 12'(rand_bits(6) * 4);
            b = a ^ 12'h084;   // Another word.
            lui(5'd14, 20'(rand_bits(20)));
            sw(5'd14, 5'd0, a);
            alu_ri(3'd0, 5'd12, 5'd0, 12'(rand_bits(12)));
            lw(5'd12, 5'd0, a);
            sw(5'd12, 5'd0, b);
            lw(5'd13, 5'd0, b);
        end
        finish_test("load_store");

        load_rd = '0;
        repeat (n_rand)
        begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            a    = 12'(rand_bits(6) * 4);
            if (rand_bits(3) == 32'd0)
            begin
                idle(1);
                load_rd = '0;
            end
            // No load-use stall in the pipeline.
            if (load_rd != 5'd0 && kind != 3'd5 &&
                (rs1 == load_rd || (rs2 == load_rd && kind < 3'd3)))
                nop();
            load_rd = '0;
            case (kind)
                3'd0, 3'd1, 3'd2: random_alu(rd, rs1, rs2, 1'b0);
                3'd3, 3'd4:       random_alu(rd, rs1, rs2, 1'b1);
                3'd5:             lui(rd, 20'(rand_bits(20)));
                3'd6:
                begin
                    lw(rd, rs1, a);
                    load_rd = rd;
                end
                default:          sw(rs2, rs1, a);
            endcase
        end
        finish_test("random");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : tb_int_pipe

`default_nettype wire

// File: verilog.f
hw/rv32i_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/forward_control_unit.sv
hw/operand_bypass.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/int_pipe_top.sv
test/tb_int_pipe.sv

// File: Makefile
SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: run clean

run: obj_dir/Vtb_int_pipe
	./obj_dir/Vtb_int_pipe | tee /dev/stderr | grep -Fqx '** PASS **'

obj_dir/Vtb_int_pipe: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_int_pipe -f verilog.f -o Vtb_int_pipe

clean:
	rm -rf obj_dir
